//--- verilog/acq_settings.svh
//////////////////////////////////////////////////////////////////////
// build-time constants for the acquisition sequencer
// trace depth must be a power of two for the index type
//////////////////////////////////////////////////////////////////////

`ifndef ACQ_SETTINGS_SVH
`define ACQ_SETTINGS_SVH

// samples captured per run
`define TRACE_DEPTH 64

// idle output cycles before pt, key, ct and trace
`define SECTION_GAP 8

// stands in for the sample taken on the ciphertext return edge
`define TRACE_MARKER 8'h37

// fixed cipher key, sent with every request
`define RUN_KEY 128'h000102030405060708090a0b0c0d0ef0

`endif

//--- verilog/acq_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared payload types for the acquisition datapath
//////////////////////////////////////////////////////////////////////

`include "acq_settings.svh"
`default_nettype none

package acq_pkg;

        typedef logic [7:0]   byte_t;
        typedef logic [7:0]   sample_t;
        typedef logic [127:0] block_t;

        // index into the trace buffer
        typedef logic [$clog2(`TRACE_DEPTH)-1:0] trace_addr_t;

        // request toward the external cipher core
        typedef struct packed {
                block_t pt;
                block_t key;
        } cipher_req_t;

        // everything the sender needs apart from the trace
        typedef struct packed {
                byte_t  param;
                block_t pt;
                block_t key;
                block_t ct;
        } run_record_t;

endpackage

`default_nettype wire

//--- verilog/stream_slice.sv
//////////////////////////////////////////////////////////////////////
// two-entry skid buffer, in_ready comes straight from a flop
// full throughput when out_ready stays high
//////////////////////////////////////////////////////////////////////

`default_nettype none

module stream_slice #(
        parameter type payload_t = logic [7:0]
) (
        input  wire      clk0,
        input  wire      c10_resetn,
        input  wire      in_valid,
        output logic     in_ready,
        input  wire payload_t in_data,
        output logic     out_valid,
        input  wire      out_ready,
        output payload_t out_data
);

        // second entry, only used while the output is stalled
        logic     skid_valid;
        payload_t skid_data;

        logic out_free;

        // output register can take a new word this cycle
        assign out_free = !out_valid || out_ready;

        // skid entry empty means room for one more
        assign in_ready = !skid_valid;

        always_ff @(posedge clk0 or negedge c10_resetn)
        begin
                if (!c10_resetn)
                begin
                        out_valid  <= 1'b0;
                        skid_valid <= 1'b0;
                end
                else if (out_free)
                begin
                        // drain skid first, else pass input through
                        out_valid  <= skid_valid || in_valid;
                        skid_valid <= 1'b0;
                end
                else if (in_valid && in_ready)
                        skid_valid <= 1'b1;
        end

        // payload flops
        always_ff @(posedge clk0)
        begin
                if (out_free)
                        out_data <= skid_valid ? skid_data : in_data;
                if (!out_free && in_valid && in_ready)
                        skid_data <= in_data;
        end

endmodule

`default_nettype wire

//--- verilog/trace_sampler.sv
//////////////////////////////////////////////////////////////////////
// captures one sensor sample per cycle after arm
// trace_full holds until the next arm, read port has 1 cycle latency
//////////////////////////////////////////////////////////////////////

`include "acq_settings.svh"
`default_nettype none

module trace_sampler
        import acq_pkg::*;
(
        input  wire         clk0,
        input  wire         c10_resetn,
        input  wire         arm,
        input  wire sample_t sensor,
        input  wire         ct_seen,
        input  wire trace_addr_t rd_addr,
        output sample_t     rd_data,
        output logic        trace_full
);

        localparam trace_addr_t last_addr = trace_addr_t'(`TRACE_DEPTH - 1);

        sample_t     mem [`TRACE_DEPTH];
        logic        active;
        trace_addr_t wr_addr;

        //////////////////////////////////////////////////////////////////////
        // capture control
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk0 or negedge c10_resetn)
        begin
                if (!c10_resetn)
                begin
                        active     <= 1'b0;
                        wr_addr    <= '0;
                        trace_full <= 1'b0;
                end
                else if (arm)
                begin
                        // first capture on the following edge
                        active     <= 1'b1;
                        wr_addr    <= '0;
                        trace_full <= 1'b0;
                end
                else if (active)
                begin
                        wr_addr <= wr_addr + 1'b1;
                        if (wr_addr == last_addr)
                        begin
                                active     <= 1'b0;
                                trace_full <= 1'b1;
                        end
                end
        end

        //////////////////////////////////////////////////////////////////////
        // buffer
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk0)
        begin
                // marker flags the ciphertext return cycle
                if (active)
                        mem[wr_addr] <= ct_seen ? `TRACE_MARKER : sensor;
                rd_data <= mem[rd_addr];
        end

endmodule

`default_nettype wire

//--- verilog/section_sender.sv
//////////////////////////////////////////////////////////////////////
// streams param, pt, key, ct, trace as bytes, blocks msb first
// idle gap before every section but the first, done when last byte leaves
//////////////////////////////////////////////////////////////////////

`include "acq_settings.svh"
`default_nettype none

module section_sender
        import acq_pkg::*;
(
        input  wire         clk0,
        input  wire         c10_resetn,
        input  wire         start,
        input  wire run_record_t record,
        output trace_addr_t rd_addr,
        input  wire sample_t rd_data,
        output logic        done,
        output logic        byte_valid,
        input  wire         byte_ready,
        output byte_t       byte_data
);

        localparam int gap_w = $clog2(`SECTION_GAP + 1);
        localparam logic [gap_w-1:0] gap_last = gap_w'(`SECTION_GAP - 1);
        localparam logic [6:0] trace_last = 7'(`TRACE_DEPTH - 1);

        typedef enum logic [1:0] {
                snd_idle,
                snd_gap,
                snd_bytes
        } snd_state_t;

        typedef enum logic [2:0] {
                sec_param,
                sec_pt,
                sec_key,
                sec_ct,
                sec_trace
        } section_t;

        snd_state_t       state;
        section_t         sec;
        logic [6:0]       cnt;
        logic [gap_w-1:0] gap_cnt;
        logic [6:0]       sec_last;
        logic             accept;

        // byte idx of a block, idx 0 is the top byte
        function automatic byte_t blk_byte(input block_t blk, input logic [3:0] idx);
                logic [6:0] lsb;
                lsb = {~idx, 3'b000};
                return blk[lsb +: 8];
        endfunction

        assign byte_valid = (state == snd_bytes);
        assign accept     = byte_valid && byte_ready;

        // look one byte ahead so rd_data is ready after the handshake
        assign rd_addr = trace_addr_t'(accept ? cnt + 7'd1 : cnt);

        always_comb
        begin
                case (sec)
                sec_param: sec_last = 7'd0;
                sec_trace: sec_last = trace_last;
                default:   sec_last = 7'd15;
                endcase
        end

        always_comb
        begin
                case (sec)
                sec_param: byte_data = record.param;
                sec_pt:    byte_data = blk_byte(record.pt, cnt[3:0]);
                sec_key:   byte_data = blk_byte(record.key, cnt[3:0]);
                sec_ct:    byte_data = blk_byte(record.ct, cnt[3:0]);
                default:   byte_data = rd_data;
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // section walk
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk0 or negedge c10_resetn)
        begin
                if (!c10_resetn)
                begin
                        state   <= snd_idle;
                        sec     <= sec_param;
                        cnt     <= '0;
                        gap_cnt <= '0;
                        done    <= 1'b0;
                end
                else
                begin
                        done <= 1'b0;
                        case (state)
                        snd_idle:
                                if (start)
                                begin
                                        sec   <= sec_param;
                                        cnt   <= '0;
                                        state <= snd_bytes;
                                end
                        snd_gap:
                        begin
                                // cnt sits at 0 here so trace entry 0 is prefetched
                                gap_cnt <= gap_cnt + 1'b1;
                                if (gap_cnt == gap_last)
                                        state <= snd_bytes;
                        end
                        snd_bytes:
                                if (accept)
                                begin
                                        if (cnt != sec_last)
                                                cnt <= cnt + 7'd1;
                                        else if (sec == sec_trace)
                                        begin
                                                done  <= 1'b1;
                                                state <= snd_idle;
                                        end
                                        else
                                        begin
                                                sec     <= section_t'(sec + 3'd1);
                                                cnt     <= '0;
                                                gap_cnt <= '0;
                                                state   <= snd_gap;
                                        end
                                end
                        default:
                                state <= snd_idle;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- verilog/run_sequencer.sv
//////////////////////////////////////////////////////////////////////
// one run per param byte, next plaintext is last ciphertext + 1
// arm assumes the cipher core takes the request as soon as it is offered
//////////////////////////////////////////////////////////////////////

`include "acq_settings.svh"
`default_nettype none

module run_sequencer
        import acq_pkg::*;
(
        input  wire         clk0,
        input  wire         c10_resetn,
        input  wire         param_valid,
        output logic        param_ready,
        input  wire byte_t  param_data,
        output logic        req_valid,
        input  wire         req_ready,
        output cipher_req_t req,
        input  wire         ct_valid,
        output logic        ct_ready,
        input  wire block_t ct_data,
        output logic        arm,
        input  wire         trace_full,
        output logic        send_start,
        input  wire         send_done,
        output run_record_t record
);

        typedef enum logic [2:0] {
                st_idle,
                st_request,
                st_wait_ct_and_trace,
                st_send,
                st_wrap
        } seq_state_t;

        seq_state_t state;
        logic       got_ct;
        logic       go_send;

        // run registers
        byte_t  param_q;
        block_t pt_q;
        block_t ct_q;

        assign param_ready = (state == st_idle);
        assign req_valid   = (state == st_request);
        assign ct_ready    = (state == st_wait_ct_and_trace) && !got_ct;
        assign go_send     = (state == st_wait_ct_and_trace) && got_ct && trace_full;

        assign req    = '{pt: pt_q, key: `RUN_KEY};
        assign record = '{param: param_q, pt: pt_q, key: `RUN_KEY, ct: ct_q};

        //////////////////////////////////////////////////////////////////////
        // main FSM
        //////////////////////////////////////////////////////////////////////

        always_ff @(posedge clk0 or negedge c10_resetn)
        begin
                if (!c10_resetn)
                begin
                        state      <= st_idle;
                        got_ct     <= 1'b0;
                        arm        <= 1'b0;
                        send_start <= 1'b0;
                        // zero + 1 for the first run
                        pt_q       <= 128'd1;
                end
                else
                begin
                        // request leaves the slice on the next edge
                        arm        <= req_valid && req_ready;
                        send_start <= go_send;
                        case (state)
                        st_idle:
                                if (param_valid)
                                begin
                                        got_ct <= 1'b0;
                                        state  <= st_request;
                                end
                        st_request:
                                if (req_ready)
                                        state <= st_wait_ct_and_trace;
                        st_wait_ct_and_trace:
                        begin
                                if (ct_valid && ct_ready)
                                        got_ct <= 1'b1;
                                if (go_send)
                                        state <= st_send;
                        end
                        st_send:
                                if (send_done)
                                        state <= st_wrap;
                        st_wrap:
                        begin
                                pt_q  <= ct_q + 128'd1;
                                state <= st_idle;
                        end
                        default:
                                state <= st_idle;
                        endcase
                end
        end

        // payload captures
        always_ff @(posedge clk0)
        begin
                if (param_valid && param_ready)
                        param_q <= param_data;
                if (ct_valid && ct_ready)
                        ct_q <= ct_data;
        end

endmodule

`default_nettype wire

//--- verilog/acq_top.sv
//////////////////////////////////////////////////////////////////////
// trace acquisition top, cipher core sits outside
// all streams are valid/ready, sensor is taken every cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none

module acq_top
        import acq_pkg::*;
(
        input  wire         clk0,
        input  wire         c10_resetn,
        input  wire         param_valid,
        output logic        param_ready,
        input  wire byte_t  param_data,
        output logic        cipher_req_valid,
        input  wire         cipher_req_ready,
        output cipher_req_t cipher_req,
        input  wire         ct_valid,
        output logic        ct_ready,
        input  wire block_t ct_data,
        input  wire sample_t sensor,
        output logic        out_valid,
        input  wire         out_ready,
        output byte_t       out_data
);

        logic        seq_req_valid;
        logic        seq_req_ready;
        cipher_req_t seq_req;
        logic        arm;
        logic        trace_full;
        logic        ct_seen;
        logic        send_start;
        logic        send_done;
        run_record_t record;
        trace_addr_t rd_addr;
        sample_t     rd_data;
        logic        snd_valid;
        logic        snd_ready;
        byte_t       snd_data;

        // marker position is the ciphertext handshake itself
        assign ct_seen = ct_valid && ct_ready;

        run_sequencer u_seq (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .param_valid(param_valid), .param_ready(param_ready),
                .param_data(param_data),
                .req_valid(seq_req_valid), .req_ready(seq_req_ready), .req(seq_req),
                .ct_valid(ct_valid), .ct_ready(ct_ready), .ct_data(ct_data),
                .arm(arm), .trace_full(trace_full),
                .send_start(send_start), .send_done(send_done), .record(record)
        );

        stream_slice #(.payload_t(cipher_req_t)) u_req_slice (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .in_valid(seq_req_valid), .in_ready(seq_req_ready), .in_data(seq_req),
                .out_valid(cipher_req_valid), .out_ready(cipher_req_ready),
                .out_data(cipher_req)
        );

        trace_sampler u_sampler (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .arm(arm), .sensor(sensor), .ct_seen(ct_seen),
                .rd_addr(rd_addr), .rd_data(rd_data), .trace_full(trace_full)
        );

        section_sender u_sender (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .start(send_start), .record(record),
                .rd_addr(rd_addr), .rd_data(rd_data), .done(send_done),
                .byte_valid(snd_valid), .byte_ready(snd_ready), .byte_data(snd_data)
        );

        stream_slice #(.payload_t(byte_t)) u_out_slice (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .in_valid(snd_valid), .in_ready(snd_ready), .in_data(snd_data),
                .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
        );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// free running testbench clock, starts low
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_clock #(
        parameter int period = 100
) (
        output logic clk0
);

        initial
        begin
                clk0 = 1'b0;
                // half period high, half low
                forever #(period / 2) clk0 = ~clk0;
        end

endmodule

`default_nettype wire

//--- test/acq_props.sv
//////////////////////////////////////////////////////////////////////
// handshake properties on the acq_top ports, bound from the testbench
// all checks are off while reset is low
//////////////////////////////////////////////////////////////////////

`default_nettype none

module acq_props
        import acq_pkg::*;
(
        input wire              clk0,
        input wire              c10_resetn,
        input wire              param_valid,
        input wire              param_ready,
        input wire              out_valid,
        input wire              out_ready,
        input wire byte_t       out_data
);

        // stalled output byte stays put
        out_hold: assert property (@(posedge clk0) disable iff (!c10_resetn)
                out_valid && !out_ready |=> out_valid && $stable(out_data))
                else $error("output byte changed or vanished while stalled");

        // one param byte per run, ready drops right after it
        param_once: assert property (@(posedge clk0) disable iff (!c10_resetn)
                param_valid && param_ready |=> !param_ready)
                else $error("param_ready stayed high after a parameter byte was taken");

endmodule

`default_nettype wire

//--- test/acq_tb.sv
//////////////////////////////////////////////////////////////////////
// random runs against a cipher model with random delay
// cipher_req_ready is held high, the trace timing relies on that
//////////////////////////////////////////////////////////////////////

`include "acq_settings.svh"
`default_nettype none

module acq_tb
        import acq_pkg::*;
();

        localparam int num_runs   = 6;
        localparam int run_bytes  = 1 + 16 + 16 + 16 + `TRACE_DEPTH;
        localparam int wait_limit = 5000;

        logic        clk0;
        logic        c10_resetn;
        logic        param_valid;
        logic        param_ready;
        byte_t       param_data;
        logic        cipher_req_valid;
        logic        cipher_req_ready;
        cipher_req_t cipher_req;
        logic        ct_valid;
        logic        ct_ready;
        block_t      ct_data;
        sample_t     sensor;
        logic        out_valid;
        logic        out_ready;
        byte_t       out_data;

        // scoreboard state
        byte_t   exp_q [$];
        sample_t exp_trace [`TRACE_DEPTH];
        block_t  exp_pt = 128'd1;
        block_t  req_pt;
        int      param_count = 0;
        int      rx_count = 0;
        int      cap_pos = 0;
        logic    capturing = 1'b0;
        logic    trace_ready = 1'b0;
        logic    got_ct = 1'b0;
        logic    stall_prev = 1'b0;
        byte_t   stall_byte;

        // cipher model state
        logic req_hit = 1'b0;
        logic ct_hit = 1'b0;
        logic pending = 1'b0;
        int   delay_left = 0;

        tb_clock clock_inst (.clk0(clk0));

        acq_top acq_top_inst (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .param_valid(param_valid), .param_ready(param_ready),
                .param_data(param_data),
                .cipher_req_valid(cipher_req_valid), .cipher_req_ready(cipher_req_ready),
                .cipher_req(cipher_req),
                .ct_valid(ct_valid), .ct_ready(ct_ready), .ct_data(ct_data),
                .sensor(sensor),
                .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
        );

        bind acq_top acq_props props_inst (
                .clk0(clk0), .c10_resetn(c10_resetn),
                .param_valid(param_valid), .param_ready(param_ready),
                .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
        );

        //////////////////////////////////////////////////////////////////////
        // error and compare tasks
        //////////////////////////////////////////////////////////////////////

        task automatic stop_with_error(input string what);
                $display("%s", what);
                $display("Some tests failed");
                $fatal(1, "stopped at the first error");
        endtask

        task automatic check_byte(input string name, input byte_t got, input byte_t exp);
                if (got !== exp)
                        stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                name, got, exp));
        endtask

        task automatic check_block(input string name, input block_t got, input block_t exp);
                if (got !== exp)
                        stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                name, got, exp));
        endtask

        task automatic check_req(input string name, input cipher_req_t got,
                input cipher_req_t exp);
                check_block({name, ".pt"}, got.pt, exp.pt);
                check_block({name, ".key"}, got.key, exp.key);
        endtask

        // blocks leave msb first
        task automatic push_block(input block_t blk);
                for (int i = 15; i >= 0; i--)
                        exp_q.push_back(blk[i * 8 +: 8]);
        endtask

        // rotate left one byte, then xor the key
        function automatic block_t model_cipher(input block_t pt);
                return {pt[119:0], pt[127:120]} ^ `RUN_KEY;
        endfunction

        //////////////////////////////////////////////////////////////////////
        // drivers, all on the falling edge
        //////////////////////////////////////////////////////////////////////

        always @(negedge clk0)
        begin
                sensor    = sample_t'($urandom);
                out_ready = ($urandom_range(9, 0) < 6);
        end

        // cipher core model
        always @(negedge clk0)
        begin
                if (ct_hit)
                begin
                        ct_valid = 1'b0;
                        ct_hit   = 1'b0;
                end
                if (req_hit)
                begin
                        req_hit    = 1'b0;
                        pending    = 1'b1;
                        delay_left = $urandom_range(75, 2);
                end
                else if (pending)
                begin
                        if (delay_left == 0)
                        begin
                                ct_valid = 1'b1;
                                ct_data  = model_cipher(req_pt);
                                pending  = 1'b0;
                        end
                        else
                                delay_left--;
                end
        end

        //////////////////////////////////////////////////////////////////////
        // monitor and scoreboard, on the rising edge
        //////////////////////////////////////////////////////////////////////

        always @(posedge clk0)
        begin
                cipher_req_t exp_req;
                logic        ct_xfer;
                if (c10_resetn)
                begin
                        ct_xfer = ct_valid && ct_ready;
                        // busy until at most two bytes of the run are left in the slice
                        if (param_ready && rx_count < param_count * run_bytes - 2)
                                stop_with_error("param_ready rose before the run finished sending");
                        if (stall_prev)
                        begin
                                if (!out_valid)
                                        stop_with_error("out_valid dropped while a byte was stalled");
                                check_byte("out_data while stalled", out_data, stall_byte);
                        end
                        stall_prev = out_valid && !out_ready;
                        stall_byte = out_data;

                        if (out_valid && out_ready)
                        begin
                                if (exp_q.size() == 0)
                                        stop_with_error("output byte arrived with nothing expected");
                                check_byte("out_data", out_data, exp_q.pop_front());
                                rx_count++;
                        end

                        if (param_valid && param_ready)
                        begin
                                exp_q.push_back(param_data);
                                param_count++;
                        end

                        // entry k is the edge k+1 after the request edge
                        if (capturing)
                        begin
                                exp_trace[cap_pos] = ct_xfer ? `TRACE_MARKER : sensor;
                                cap_pos++;
                                if (cap_pos == `TRACE_DEPTH)
                                begin
                                        capturing   = 1'b0;
                                        trace_ready = 1'b1;
                                end
                        end

                        if (cipher_req_valid && cipher_req_ready)
                        begin
                                exp_req.pt  = exp_pt;
                                exp_req.key = `RUN_KEY;
                                check_req("cipher_req", cipher_req, exp_req);
                                push_block(exp_pt);
                                push_block(`RUN_KEY);
                                req_pt    = exp_pt;
                                req_hit   = 1'b1;
                                capturing = 1'b1;
                                cap_pos   = 0;
                        end

                        if (ct_xfer)
                        begin
                                push_block(ct_data);
                                exp_pt = ct_data + 128'd1;
                                got_ct = 1'b1;
                                ct_hit = 1'b1;
                        end

                        // trace goes out after the ciphertext
                        if (got_ct && trace_ready)
                        begin
                                for (int k = 0; k < `TRACE_DEPTH; k++)
                                        exp_q.push_back(exp_trace[k]);
                                got_ct      = 1'b0;
                                trace_ready = 1'b0;
                        end
                end
        end

        //////////////////////////////////////////////////////////////////////
        // waits
        //////////////////////////////////////////////////////////////////////

        task automatic wait_param_taken(input int n);
                int waited;
                waited = 0;
                while (param_count < n && waited < wait_limit)
                begin
                        @(negedge clk0);
                        waited++;
                end
                if (param_count < n)
                        stop_with_error($sformatf("parameter byte %0d was never accepted", n));
        endtask

        task automatic wait_all_bytes();
                int waited;
                waited = 0;
                while (rx_count < num_runs * run_bytes && waited < wait_limit)
                begin
                        @(negedge clk0);
                        waited++;
                end
                if (rx_count < num_runs * run_bytes)
                        stop_with_error("the last run did not send all its bytes");
        endtask

        //////////////////////////////////////////////////////////////////////
        // main sequence
        //////////////////////////////////////////////////////////////////////

        initial
        begin
                void'($urandom(45));
                c10_resetn       = 1'b0;
                param_valid      = 1'b0;
                param_data       = '0;
                cipher_req_ready = 1'b1;
                ct_valid         = 1'b0;
                ct_data          = '0;
                sensor           = '0;
                out_ready        = 1'b0;

                repeat (8) @(posedge clk0);
                @(negedge clk0);
                c10_resetn = 1'b1;
                @(negedge clk0);
                if (!param_ready || cipher_req_valid || out_valid)
                        stop_with_error("ports were not idle after reset");

                // next byte is offered as soon as the previous one is taken
                for (int r = 0; r < num_runs; r++)
                begin
                        param_valid = 1'b1;
                        param_data  = byte_t'($urandom);
                        wait_param_taken(r + 1);
                end
                param_valid = 1'b0;

                wait_all_bytes();
                if (exp_q.size() != 0 || param_count != num_runs)
                        stop_with_error("byte or run count differs at the end of the run");
                else
                begin
                        $display("All tests passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- acq.f
+incdir+verilog
verilog/acq_pkg.sv
verilog/stream_slice.sv
verilog/trace_sampler.sv
verilog/section_sender.sv
verilog/run_sequencer.sv
verilog/acq_top.sv
test/tb_clock.sv
test/acq_props.sv
test/acq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the acquisition testbench with Verilator and runs it
# the run fails if the log holds the fail message or lacks the pass message

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -Wno-fatal --top-module acq_tb -f acq.f \
        -Mdir obj_dir -o acq_sim > build.log 2>&1 \
        || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/acq_sim > sim.log 2>&1
cat sim.log

grep -q "Some tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
